// ==== filelist.f ====
hw/axi4s_pkg.sv
hw/axi4s_intf.sv
hw/bus_intf.sv
hw/bus_reg_slice.sv
hw/bus_rdy_pipe.sv
hw/bus_pipe_auto.sv
hw/axi4s_pipe_auto.sv
hw/axi4s_pipe_top.sv
testbench/tb_axi4s_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI4-S pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_axi4s_pipe -f filelist.f -o tb_axi4s_pipe

./obj_dir/tb_axi4s_pipe | tee "$LOG"

# The testbench prints the pass message only when every check passed
if grep -q "^Test OK$" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== testbench/tb_axi4s_pipe.sv ====
/*
 * Testbench for the AXI4-S pipeline stage
 * Random beats checked against a queue model, plus latency, flow and drain checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi4s_pipe;
    import axi4s_pkg::*;

    localparam int SEED         = 33;
    localparam int RESET_CYCLES = 8;
    localparam int FLOW_BEATS   = 200;
    localparam int RANDOM_BEATS = 600;
    localparam int TOTAL_BEATS  = 1 + FLOW_BEATS + RANDOM_BEATS;
    localparam int IDLE_CYCLES  = 20;
    localparam int WAIT_LIMIT   = 50;
    // About three times the length of all phases together
    localparam int MAX_CYCLES   = 4000;
    // Edges from input transfer to output beat in an empty pipe
    localparam int LATENCY      = FWD_STAGES + 1;
    // in_tready is the first slice's ready register, set one edge after release
    // and therefore seen high at the edge after that
    localparam int READY_EDGES  = 2;

    typedef struct packed {
        tuser_t tuser;
        tdest_t tdest;
        tid_t   tid;
        logic   tlast;
        tkeep_t tkeep;
        tdata_t tdata;
    } beat_t;

    logic   aclk;
    logic   rst_n;
    logic   in_tvalid;
    logic   in_tready;
    tdata_t in_tdata;
    tkeep_t in_tkeep;
    logic   in_tlast;
    tid_t   in_tid;
    tdest_t in_tdest;
    tuser_t in_tuser;
    logic   out_tvalid;
    logic   out_tready;
    tdata_t out_tdata;
    tkeep_t out_tkeep;
    logic   out_tlast;
    tid_t   out_tid;
    tdest_t out_tdest;
    tuser_t out_tuser;

    beat_t exp_q[$];
    int    errors      = 0;
    int    check_count = 0;
    int    in_count    = 0;
    int    out_count   = 0;

    axi4s_pipe_top dut0 (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tdata   (in_tdata),
        .in_tkeep   (in_tkeep),
        .in_tlast   (in_tlast),
        .in_tid     (in_tid),
        .in_tdest   (in_tdest),
        .in_tuser   (in_tuser),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tlast  (out_tlast),
        .out_tid    (out_tid),
        .out_tdest  (out_tdest),
        .out_tuser  (out_tuser)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("Fail %s: expected 0x%0h, got 0x%0h", sig, exp_val, act_val);
        errors++;
    endtask

    // Called right after a rising edge
    task automatic drive_random_beat();
        in_tvalid <= 1'b1;
        in_tdata  <= tdata_t'($urandom);
        in_tkeep  <= tkeep_t'($urandom);
        in_tlast  <= 1'($urandom);
        in_tid    <= tid_t'($urandom);
        in_tdest  <= tdest_t'($urandom);
        in_tuser  <= tuser_t'($urandom);
    endtask

    // Queue model that holds accepted beats until they leave the pipe
    always @(posedge aclk) begin
        beat_t exp_beat;
        if (in_tvalid && in_tready) begin
            exp_q.push_back({in_tuser, in_tdest, in_tid, in_tlast, in_tkeep, in_tdata});
            in_count++;
        end
        if (out_tvalid && out_tready) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Output beat %0d left the pipe with no input beat to match", out_count);
                errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                check_count++;
                if (out_tdata !== exp_beat.tdata)
                    report_mismatch("out_tdata", 64'(exp_beat.tdata), 64'(out_tdata));
                if (out_tkeep !== exp_beat.tkeep)
                    report_mismatch("out_tkeep", 64'(exp_beat.tkeep), 64'(out_tkeep));
                if (out_tlast !== exp_beat.tlast)
                    report_mismatch("out_tlast", 64'(exp_beat.tlast), 64'(out_tlast));
                if (out_tid !== exp_beat.tid)
                    report_mismatch("out_tid", 64'(exp_beat.tid), 64'(out_tid));
                if (out_tdest !== exp_beat.tdest)
                    report_mismatch("out_tdest", 64'(exp_beat.tdest), 64'(out_tdest));
                if (out_tuser !== exp_beat.tuser)
                    report_mismatch("out_tuser", 64'(exp_beat.tuser), 64'(out_tuser));
            end
        end
    end

    task automatic check_reset();
        int n;
        for (n = 1; n <= RESET_CYCLES; n++) begin
            @(posedge aclk);
            // First edge may still show uninitialized registers
            if (n > 1 && in_tready !== 1'b0)
                report_mismatch("in_tready", 64'(0), 64'(in_tready));
            if (n > 1 && out_tvalid !== 1'b0)
                report_mismatch("out_tvalid", 64'(0), 64'(out_tvalid));
        end
        rst_n <= 1'b1;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            if (out_tvalid !== 1'b0)
                report_mismatch("out_tvalid", 64'(0), 64'(out_tvalid));
        end while (in_tready !== 1'b1 && n < WAIT_LIMIT);
        if (in_tready !== 1'b1) begin
            $display("in_tready never rose after reset was released");
            errors++;
        end else if (n != READY_EDGES) begin
            report_mismatch("in_tready rise edge", 64'(READY_EDGES), 64'(n));
        end
    endtask

    task automatic run_latency_beat();
        int n;
        @(posedge aclk);
        out_tready <= 1'b1;
        drive_random_beat();
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (in_tready !== 1'b1 && n < WAIT_LIMIT);
        in_tvalid <= 1'b0;
        if (in_tready !== 1'b1) begin
            $display("Idle pipe did not accept a single input beat");
            errors++;
        end
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (out_tvalid !== 1'b1 && n < WAIT_LIMIT);
        if (out_tvalid !== 1'b1) begin
            $display("Single beat never reached the outputs of the idle pipe");
            errors++;
        end else if (n != LATENCY) begin
            report_mismatch("out_tvalid latency", 64'(LATENCY), 64'(n));
        end
    endtask

    task automatic run_continuous_flow();
        int sent;
        int recv;
        bit seen_first;
        sent       = 0;
        recv       = 0;
        seen_first = 0;
        @(posedge aclk);
        drive_random_beat();
        while (recv < FLOW_BEATS) begin
            @(posedge aclk);
            if (in_tvalid && in_tready)
                sent++;
            if (out_tvalid && out_tready) begin
                recv++;
                seen_first = 1;
            end else if (seen_first) begin
                $display("Gap in continuous flow after %0d output beats", recv);
                errors++;
            end
            if (in_tvalid && !in_tready) begin
                // Hold the current beat
            end else if (sent < FLOW_BEATS) begin
                drive_random_beat();
            end else begin
                in_tvalid <= 1'b0;
            end
        end
    endtask

    task automatic run_random_flow();
        int sent;
        sent = 0;
        @(posedge aclk);
        while (sent < RANDOM_BEATS) begin
            @(posedge aclk);
            if (in_tvalid && in_tready)
                sent++;
            out_tready <= 1'($urandom);
            if (in_tvalid && !in_tready) begin
                // Beat stays stable until it transfers
            end else if (sent < RANDOM_BEATS && 1'($urandom)) begin
                drive_random_beat();
            end else begin
                in_tvalid <= 1'b0;
            end
        end
    endtask

    task automatic check_drain();
        int idle;
        int n;
        idle = 0;
        n    = 0;
        out_tready <= 1'b1;
        while (idle < IDLE_CYCLES && n < 10 * IDLE_CYCLES) begin
            @(posedge aclk);
            n++;
            idle = out_tvalid ? 0 : idle + 1;
        end
        if (idle < IDLE_CYCLES) begin
            $display("Outputs never went idle after the stimulus ended");
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d beats were accepted but never left the pipe", exp_q.size());
            errors++;
        end
        if (in_count != TOTAL_BEATS)
            report_mismatch("input beat count", 64'(TOTAL_BEATS), 64'(in_count));
        if (out_count != TOTAL_BEATS)
            report_mismatch("output beat count", 64'(TOTAL_BEATS), 64'(out_count));
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      <= 1'b0;
        in_tvalid  <= 1'b0;
        in_tdata   <= '0;
        in_tkeep   <= '0;
        in_tlast   <= 1'b0;
        in_tid     <= '0;
        in_tdest   <= '0;
        in_tuser   <= '0;
        out_tready <= 1'b0;
        check_reset();
        run_latency_beat();
        run_continuous_flow();
        run_random_flow();
        check_drain();
        $display("Beats checked: %0d, errors: %0d", check_count, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge aclk);
        $display("Run stopped after %0d cycles without finishing, beats checked: %0d, errors: %0d",
                 MAX_CYCLES, check_count, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule : tb_axi4s_pipe

`default_nettype wire

// ==== hw/axi4s_pipe_top.sv ====
/*
 * AXI4-S pipeline top level
 * Plain stream ports on both sides of the pipeline stage
 */
`timescale 1ns/1ps
`default_nettype none

module axi4s_pipe_top (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              in_tvalid,
    output logic              in_tready,
    input  axi4s_pkg::tdata_t in_tdata,
    input  axi4s_pkg::tkeep_t in_tkeep,
    input  logic              in_tlast,
    input  axi4s_pkg::tid_t   in_tid,
    input  axi4s_pkg::tdest_t in_tdest,
    input  axi4s_pkg::tuser_t in_tuser,
    output logic              out_tvalid,
    input  logic              out_tready,
    output axi4s_pkg::tdata_t out_tdata,
    output axi4s_pkg::tkeep_t out_tkeep,
    output logic              out_tlast,
    output axi4s_pkg::tid_t   out_tid,
    output axi4s_pkg::tdest_t out_tdest,
    output axi4s_pkg::tuser_t out_tuser
);

    axi4s_intf from_tx (.aclk(aclk));
    axi4s_intf to_rx   (.aclk(aclk));

    // Input side
    assign from_tx.tvalid = in_tvalid;
    assign from_tx.tdata  = in_tdata;
    assign from_tx.tkeep  = in_tkeep;
    assign from_tx.tlast  = in_tlast;
    assign from_tx.tid    = in_tid;
    assign from_tx.tdest  = in_tdest;
    assign from_tx.tuser  = in_tuser;
    assign in_tready      = from_tx.tready;

    axi4s_pipe_auto u_pipe (
        .rst_n   (rst_n),
        .from_tx (from_tx),
        .to_rx   (to_rx)
    );

    // Output side
    assign out_tvalid   = to_rx.tvalid;
    assign out_tdata    = to_rx.tdata;
    assign out_tkeep    = to_rx.tkeep;
    assign out_tlast    = to_rx.tlast;
    assign out_tid      = to_rx.tid;
    assign out_tdest    = to_rx.tdest;
    assign out_tuser    = to_rx.tuser;
    assign to_rx.tready = out_tready;

endmodule : axi4s_pipe_top

`default_nettype wire

// ==== hw/axi4s_pipe_auto.sv ====
/*
 * AXI4-S pipeline stage
 * Packs the stream fields into one payload word, pipes it and unpacks it
 */
`timescale 1ns/1ps
`default_nettype none

module axi4s_pipe_auto (
    input logic   rst_n,
    axi4s_intf.rx from_tx,
    axi4s_intf.tx to_rx
);
    import axi4s_pkg::*;

    logic     clk;
    payload_t in_payload;
    payload_t out_payload;

    assign clk = from_tx.aclk;

    bus_intf bus_in  (.clk(clk));
    bus_intf bus_out (.clk(clk));

    // Pack in package field order
    always_comb begin
        in_payload = '0;
        in_payload[TDATA_LSB +: TDATA_WID] = from_tx.tdata;
        in_payload[TKEEP_LSB +: TKEEP_WID] = from_tx.tkeep;
        in_payload[TLAST_LSB]              = from_tx.tlast;
        in_payload[TID_LSB   +: TID_WID]   = from_tx.tid;
        in_payload[TDEST_LSB +: TDEST_WID] = from_tx.tdest;
        in_payload[TUSER_LSB +: TUSER_WID] = from_tx.tuser;
    end

    assign bus_in.valid   = from_tx.tvalid;
    assign bus_in.data    = in_payload;
    assign from_tx.tready = bus_in.ready;

    bus_pipe_auto u_bus_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .from_tx (bus_in),
        .to_rx   (bus_out)
    );

    assign out_payload   = bus_out.data;
    assign bus_out.ready = to_rx.tready;
    assign to_rx.tvalid  = bus_out.valid;

    // Unpack
    assign to_rx.tdata = out_payload[TDATA_LSB +: TDATA_WID];
    assign to_rx.tkeep = out_payload[TKEEP_LSB +: TKEEP_WID];
    assign to_rx.tlast = out_payload[TLAST_LSB];
    assign to_rx.tid   = out_payload[TID_LSB   +: TID_WID];
    assign to_rx.tdest = out_payload[TDEST_LSB +: TDEST_WID];
    assign to_rx.tuser = out_payload[TUSER_LSB +: TUSER_WID];

endmodule : axi4s_pipe_auto

`default_nettype wire

// ==== hw/bus_pipe_auto.sv ====
/*
 * Bus pipeline
 * Chain of forward register slices followed by the reverse-ready stage
 */
`timescale 1ns/1ps
`default_nettype none

module bus_pipe_auto #(
    parameter int FWD_STAGES = axi4s_pkg::FWD_STAGES,
    parameter int REV_STAGES = axi4s_pkg::REV_STAGES
) (
    input logic clk,
    input logic rst_n,
    bus_intf.rx from_tx,
    bus_intf.tx to_rx
);

    // Link 0 is the pipe input, link FWD_STAGES feeds the ready stage
    bus_intf link_if [FWD_STAGES+1] (.clk(clk));

    assign link_if[0].valid = from_tx.valid;
    assign link_if[0].data  = from_tx.data;
    assign from_tx.ready    = link_if[0].ready;

    for (genvar i = 0; i < FWD_STAGES; i++) begin : g_fwd
        bus_reg_slice u_slice (
            .clk     (clk),
            .rst_n   (rst_n),
            .from_tx (link_if[i]),
            .to_rx   (link_if[i+1])
        );
    end

    bus_rdy_pipe #(
        .REV_STAGES (REV_STAGES)
    ) u_rdy_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .from_tx (link_if[FWD_STAGES]),
        .to_rx   (to_rx)
    );

endmodule : bus_pipe_auto

`default_nettype wire

// ==== hw/bus_rdy_pipe.sv ====
/*
 * Reverse-path pipeline stage
 * Delays ready through a shift register and absorbs in-flight beats
 * in a small FIFO with a registered output
 */
`timescale 1ns/1ps
`default_nettype none

module bus_rdy_pipe #(
    parameter int REV_STAGES = axi4s_pkg::REV_STAGES
) (
    input logic clk,
    input logic rst_n,
    bus_intf.rx from_tx,
    bus_intf.tx to_rx
);
    import axi4s_pkg::*;

    // Room for every beat still in flight after raw ready drops
    localparam int DEPTH = 2 * REV_STAGES + 2;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      free_cnt;
    logic [REV_STAGES-1:0] rdy_sr;
    logic                  raw_ready;

    logic     out_valid;
    payload_t out_data;

    logic push;
    logic out_ld;
    logic mem_rd;
    logic mem_wr;
    logic bypass;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign free_cnt  = CNT_W'(DEPTH) - count;
    assign raw_ready = free_cnt > CNT_W'(REV_STAGES + 1);

    assign from_tx.ready = rdy_sr[REV_STAGES-1];
    assign push          = from_tx.valid && from_tx.ready;

    // Output register takes the FIFO head, or the input when the FIFO is empty
    assign out_ld = !out_valid || to_rx.ready;
    assign mem_rd = out_ld && (count != '0);
    assign bypass = out_ld && (count == '0) && push;
    assign mem_wr = push && !bypass;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_sr    <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            rdy_sr[0] <= raw_ready;
            for (int i = 1; i < REV_STAGES; i++) begin
                rdy_sr[i] <= rdy_sr[i-1];
            end
            if (mem_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (mem_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(mem_wr) - CNT_W'(mem_rd);
            if (out_ld) begin
                out_valid <= mem_rd || push;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= from_tx.data;
        end
        if (mem_rd) begin
            out_data <= mem[rd_ptr];
        end else if (bypass) begin
            out_data <= from_tx.data;
        end
    end

    assign to_rx.valid = out_valid;
    assign to_rx.data  = out_data;

endmodule : bus_rdy_pipe

`default_nettype wire

// ==== hw/bus_reg_slice.sv ====
/*
 * Two-entry register slice
 * Registers valid, data and ready so that no path crosses the slice
 */
`timescale 1ns/1ps
`default_nettype none

module bus_reg_slice (
    input logic clk,
    input logic rst_n,
    bus_intf.rx from_tx,
    bus_intf.tx to_rx
);
    import axi4s_pkg::*;

    logic     main_valid;
    logic     skid_valid;
    logic     ready_q;
    payload_t main_data;
    payload_t skid_data;

    logic push;
    logic main_ld;
    logic main_valid_nxt;
    logic skid_valid_nxt;

    // Ready is high only while the skid entry is free
    assign push    = from_tx.valid && ready_q;
    assign main_ld = !main_valid || to_rx.ready;

    always_comb begin
        main_valid_nxt = main_valid;
        skid_valid_nxt = skid_valid;
        if (main_ld) begin
            // Main entry refills from skid first to keep order
            main_valid_nxt = skid_valid || push;
            skid_valid_nxt = 1'b0;
        end else if (push) begin
            skid_valid_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            main_valid <= main_valid_nxt;
            skid_valid <= skid_valid_nxt;
            ready_q    <= !skid_valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (main_ld) begin
            if (skid_valid) begin
                main_data <= skid_data;
            end else if (push) begin
                main_data <= from_tx.data;
            end
        end else if (push) begin
            skid_data <= from_tx.data;
        end
    end

    assign from_tx.ready = ready_q;
    assign to_rx.valid   = main_valid;
    assign to_rx.data    = main_data;

endmodule : bus_reg_slice

`default_nettype wire

// ==== hw/bus_intf.sv ====
/*
 * Generic valid/ready bus
 * Carries one opaque packed payload word per beat
 */
`timescale 1ns/1ps
`default_nettype none

interface bus_intf (
    input logic clk
);
    import axi4s_pkg::*;

    logic     valid;
    logic     ready;
    payload_t data;

    modport tx (input clk, output valid, output data, input ready);

    modport rx (input clk, input valid, input data, output ready);

endinterface : bus_intf

`default_nettype wire

// ==== hw/axi4s_intf.sv ====
/*
 * AXI4-S interface
 * Clock, handshake and all stream fields with sender/receiver views
 */
`timescale 1ns/1ps
`default_nettype none

interface axi4s_intf (
    input logic aclk
);
    import axi4s_pkg::*;

    logic   tvalid;
    logic   tready;
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;
    tid_t   tid;
    tdest_t tdest;
    tuser_t tuser;

    // Sender side
    modport tx (
        input  aclk,
        output tvalid, tdata, tkeep, tlast, tid, tdest, tuser,
        input  tready
    );

    // Receiver side
    modport rx (
        input  aclk,
        input  tvalid, tdata, tkeep, tlast, tid, tdest, tuser,
        output tready
    );

endinterface : axi4s_intf

`default_nettype wire

// ==== hw/axi4s_pkg.sv ====
/*
 * AXI4-S pipeline package
 * Stream field widths, packed payload layout and default stage counts
 */
`default_nettype none

package axi4s_pkg;

    // Stream field widths
    localparam int DATA_BYTE_WID = 4;
    localparam int TID_WID       = 2;
    localparam int TDEST_WID     = 2;
    localparam int TUSER_WID     = 4;
    localparam int TDATA_WID     = DATA_BYTE_WID * 8;
    localparam int TKEEP_WID     = DATA_BYTE_WID;

    // Low bit of each field in the payload word, LSB upward
    localparam int TDATA_LSB = 0;
    localparam int TKEEP_LSB = TDATA_LSB + TDATA_WID;
    localparam int TLAST_LSB = TKEEP_LSB + TKEEP_WID;
    localparam int TID_LSB   = TLAST_LSB + 1;
    localparam int TDEST_LSB = TID_LSB + TID_WID;
    localparam int TUSER_LSB = TDEST_LSB + TDEST_WID;

    localparam int PAYLOAD_WID = TUSER_LSB + TUSER_WID;

    // Default pipeline depth in each direction
    localparam int FWD_STAGES = 2;
    localparam int REV_STAGES = 2;

    typedef logic [TDATA_WID-1:0]   tdata_t;
    typedef logic [TKEEP_WID-1:0]   tkeep_t;
    typedef logic [TID_WID-1:0]     tid_t;
    typedef logic [TDEST_WID-1:0]   tdest_t;
    typedef logic [TUSER_WID-1:0]   tuser_t;
    typedef logic [PAYLOAD_WID-1:0] payload_t;

endpackage : axi4s_pkg

`default_nettype wire
